// File: dbg_trig_unit.f
hw/dbg_trig_pkg.sv
hw/dbg_trig_comparator.sv
hw/dbg_trig_match_bank.sv
hw/dbg_trig_regs.sv
hw/dbg_trig_unit.sv
verification/tb_dbg_trig_unit.sv

// File: Bender.yml
package:
  name: dbg_trig_unit

sources:
  # Package first, then leaf modules up to the top level
  - files:
      - hw/dbg_trig_pkg.sv
      - hw/dbg_trig_comparator.sv
      - hw/dbg_trig_match_bank.sv
      - hw/dbg_trig_regs.sv
      - hw/dbg_trig_unit.sv

  - target: test
    files:
      - verification/tb_dbg_trig_unit.sv

// File: verification/tb_dbg_trig_unit.sv
// Testbench for the debug trigger unit with an APB driver, a register and match model, and checks
`default_nettype none

module tb_dbg_trig_unit;

  timeunit 1ns;
  timeprecision 100ps;

  import dbg_trig_pkg::*;

  localparam int unsigned NUM_TRIG   = 2;
  localparam int unsigned MAX_CYCLES = 4000;  // Well above the stimulus length

  logic      clk;
  logic      rst_n_i;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  if_fetch_t if_fetch;
  lsu_req_t  lsu_req;
  wb_exc_t   wb_exc;
  logic      debug_mode;
  logic      match_if;
  logic      match_ex;
  logic      etrigger_wb;

  xlen_t       m_tselect;           // Model of tselect
  xlen_t       m_tdata1 [NUM_TRIG];
  xlen_t       m_tdata2 [NUM_TRIG];
  int unsigned err_match;
  int unsigned err_bus;
  int unsigned err_other;
  int unsigned hits_if;             // Expected hits per match output
  int unsigned hits_ex;
  int unsigned hits_wb;
  int unsigned cycle_cnt;

  dbg_trig_unit #(
    .NUM_TRIGGERS (NUM_TRIG)
  ) UUT (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .apb_req_i     (apb_req),
    .apb_rsp_o     (apb_rsp),
    .if_fetch_i    (if_fetch),
    .lsu_req_i     (lsu_req),
    .wb_exc_i      (wb_exc),
    .debug_mode_i  (debug_mode),
    .match_if_o    (match_if),
    .match_ex_o    (match_ex),
    .etrigger_wb_o (etrigger_wb)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // WARL rules applied at the edge that ends the access phase
  task automatic model_write(input apb_addr_t addr, input xlen_t data);
    logic [3:0]  mode;
    int unsigned sel;
    sel  = m_tselect;
    mode = data[10:7];
    case (addr)
      REG_TSELECT: if (data < NUM_TRIG) m_tselect = data;
      REG_TDATA1: begin
        if ((data == '0) || (data[31:28] == 4'hF)) begin
          m_tdata1[sel] = TDATA1_DISABLED_VAL;
        end else if (data[31:28] == 4'h6) begin
          if ((mode != 4'd2) && (mode != 4'd3)) mode = 4'd0;  // Unsupported modes become EQ
          m_tdata1[sel] = 32'h6800_1000 | (xlen_t'(mode) << 7) | (data & 32'h0000_0047);
        end else if ((data[31:28] == 4'h5) && ((m_tdata2[sel] & ~ETRIG_TDATA2_MASK) == '0)) begin
          m_tdata1[sel] = 32'h5800_0001 | (data & 32'h0000_0200);
        end
      end
      REG_TDATA2: begin
        m_tdata2[sel] = (m_tdata1[sel][31:28] == 4'h5) ? (data & ETRIG_TDATA2_MASK) : data;
      end
      default: ;  // TINFO and holes change nothing
    endcase
  endtask

  function automatic logic is_mapped(input apb_addr_t addr);
    return addr inside {4'h0, 4'h4, 4'h8, 4'hC};
  endfunction

  function automatic xlen_t exp_rdata(input apb_addr_t addr);
    case (addr)
      REG_TSELECT: return m_tselect;
      REG_TDATA1:  return m_tdata1[m_tselect];
      REG_TDATA2:  return m_tdata2[m_tselect];
      REG_TINFO:   return 32'h0000_8060;
      default:     return '0;
    endcase
  endfunction

  function automatic logic exp_if_hit();
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_TRIG; i++) begin
      if ((m_tdata1[i][31:28] == 4'h6) && m_tdata1[i][2] && m_tdata1[i][6] &&
          (if_fetch.priv == PRIV_M) && !debug_mode && !if_fetch.ptr) begin
        case (m_tdata1[i][10:7])
          4'd0:    hit |= (if_fetch.pc == m_tdata2[i]);
          4'd2:    hit |= (if_fetch.pc >= m_tdata2[i]);
          default: hit |= (if_fetch.pc < m_tdata2[i]);
        endcase
      end
    end
    return hit;
  endfunction

  function automatic logic exp_ex_hit();
    logic       hit;
    logic       found;
    logic [1:0] lo;
    logic [1:0] hi;
    hit   = 1'b0;
    found = 1'b0;
    lo    = 2'd0;
    hi    = 2'd0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_req.be[b]) begin
        if (!found) lo = 2'(b);
        hi    = 2'(b);
        found = 1'b1;
      end
    end
    for (int i = 0; i < NUM_TRIG; i++) begin
      if ((m_tdata1[i][31:28] == 4'h6) && lsu_req.valid && m_tdata1[i][6] &&
          (lsu_req.priv == PRIV_M) && !debug_mode &&
          (lsu_req.we ? m_tdata1[i][1] : m_tdata1[i][0])) begin
        case (m_tdata1[i][10:7])
          4'd0: hit |= (lsu_req.addr[31:2] == m_tdata2[i][31:2]) && lsu_req.be[m_tdata2[i][1:0]];
          4'd2: hit |= ({lsu_req.addr[31:2], hi} >= m_tdata2[i]);
          default: hit |= ({lsu_req.addr[31:2], lo} < m_tdata2[i]);
        endcase
      end
    end
    return hit;
  endfunction

  function automatic logic exp_wb_hit();
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_TRIG; i++) begin
      if ((m_tdata1[i][31:28] == 4'h5) && m_tdata1[i][9] && wb_exc.exception &&
          (wb_exc.priv == PRIV_M) && !debug_mode && (wb_exc.cause < 11'd32)) begin
        hit |= m_tdata2[i][wb_exc.cause[4:0]];
      end
    end
    return hit;
  endfunction

  ////////////////////////////////////////
  // Checks at the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n_i) begin
      hits_if += exp_if_hit();
      hits_ex += exp_ex_hit();
      hits_wb += exp_wb_hit();
      assert (match_if === exp_if_hit()) else begin
        err_match++;
        $display("mismatch match_if_o: got %h expected %h", match_if, exp_if_hit());
      end
      assert (match_ex === exp_ex_hit()) else begin
        err_match++;
        $display("mismatch match_ex_o: got %h expected %h", match_ex, exp_ex_hit());
      end
      assert (etrigger_wb === exp_wb_hit()) else begin
        err_match++;
        $display("mismatch etrigger_wb_o: got %h expected %h", etrigger_wb, exp_wb_hit());
      end
      assert (apb_rsp.pready === 1'b1) else begin
        err_bus++;
        $display("mismatch pready: got %h expected 1", apb_rsp.pready);
      end
      if (apb_req.psel && apb_req.penable) begin  // Access phase
        assert (apb_rsp.pslverr === !is_mapped(apb_req.paddr)) else begin
          err_bus++;
          $display("mismatch pslverr at offset %h: got %h expected %h", apb_req.paddr,
                   apb_rsp.pslverr, !is_mapped(apb_req.paddr));
        end
        if (!apb_req.pwrite) begin
          assert (apb_rsp.prdata === exp_rdata(apb_req.paddr)) else begin
            err_bus++;
            $display("mismatch prdata at offset %h: got %h expected %h", apb_req.paddr,
                     apb_rsp.prdata, exp_rdata(apb_req.paddr));
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic apb_xfer(input logic write, input apb_addr_t addr, input xlen_t data);
    @(posedge clk);
    apb_req.psel    <= 1'b1;  // Setup phase
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req <= '0;
    if (write) model_write(addr, data);
  endtask

  task automatic apb_write(input apb_addr_t addr, input xlen_t data);
    apb_xfer(1'b1, addr, data);
  endtask

  task automatic apb_read(input apb_addr_t addr);
    apb_xfer(1'b0, addr, '0);
  endtask

  // Random traffic on all three stages around one address
  task automatic drive_core(input int unsigned n, input xlen_t base);
    for (int unsigned k = 0; k < n; k++) begin
      @(posedge clk);
      if_fetch.pc      <= base + xlen_t'($urandom_range(0, 6)) - 32'd3;
      if_fetch.ptr     <= ($urandom_range(0, 4) == 0);
      if_fetch.priv    <= ($urandom_range(0, 3) == 0) ? PRIV_U : PRIV_M;
      lsu_req.valid    <= ($urandom_range(0, 5) != 0);
      lsu_req.addr     <= base + xlen_t'($urandom_range(0, 12)) - 32'd6;
      lsu_req.we       <= 1'($urandom_range(0, 1));
      lsu_req.be       <= 4'($urandom_range(1, 15));
      lsu_req.priv     <= ($urandom_range(0, 3) == 0) ? PRIV_U : PRIV_M;
      wb_exc.exception <= ($urandom_range(0, 3) != 0);
      wb_exc.cause     <= cause_t'($urandom_range(0, 40));  // Includes causes of 32 and up
      wb_exc.priv      <= ($urandom_range(0, 3) == 0) ? PRIV_U : PRIV_M;
      debug_mode       <= ($urandom_range(0, 5) == 0);
    end
  endtask

  initial begin
    xlen_t      base;
    logic [3:0] mode;
    void'($urandom(32'h0b61_d7f2));
    apb_req    = '0;
    if_fetch   = '0;
    lsu_req    = '0;
    wb_exc     = '0;
    debug_mode = 1'b0;
    rst_n_i    = 1'b0;
    m_tselect  = '0;
    for (int i = 0; i < NUM_TRIG; i++) begin
      m_tdata1[i] = TDATA1_DISABLED_VAL;
      m_tdata2[i] = '0;
    end
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;

    // Reset values, tinfo and an unmapped offset
    apb_read(REG_TSELECT);
    apb_read(REG_TDATA1);
    apb_read(REG_TDATA2);
    apb_read(REG_TINFO);
    apb_write(REG_TINFO, 32'hFFFF_FFFF);   // Read-only without error
    apb_read(REG_TINFO);
    apb_read(4'h6);
    apb_write(4'h6, 32'h6000_0044);        // Must not reach tdata1
    apb_read(REG_TDATA1);

    // WARL on tselect and tdata1
    apb_write(REG_TSELECT, 32'd2);
    apb_read(REG_TSELECT);
    apb_write(REG_TSELECT, 32'd1);
    apb_write(REG_TSELECT, 32'd7);
    apb_read(REG_TSELECT);
    apb_write(REG_TSELECT, 32'd0);
    for (int k = 0; k < 8; k++) begin
      apb_write(REG_TDATA1, {4'h6, 28'($urandom())});
      apb_read(REG_TDATA1);
    end
    apb_write(REG_TDATA1, 32'h6000_00C7);  // Match 1 falls back to EQ
    apb_read(REG_TDATA1);
    apb_write(REG_TDATA1, 32'h3000_0044);  // Unknown type
    apb_read(REG_TDATA1);
    apb_write(REG_TDATA2, 32'h0000_0100);  // Code 8 is not implemented
    apb_write(REG_TDATA1, 32'h5000_0200);  // Refused
    apb_read(REG_TDATA1);
    apb_write(REG_TDATA2, 32'h0000_0003);
    apb_write(REG_TDATA1, 32'h5000_0200);
    apb_write(REG_TDATA2, 32'hFFFF_FFFF);  // Masked
    apb_read(REG_TDATA1);
    apb_read(REG_TDATA2);
    apb_write(REG_TSELECT, 32'd1);
    apb_write(REG_TDATA1, 32'h6000_0183);
    apb_write(REG_TDATA2, $urandom());
    apb_read(REG_TDATA1);
    apb_read(REG_TDATA2);
    apb_write(REG_TDATA1, 32'h0);           // Zero disables
    apb_write(REG_TSELECT, 32'd0);
    apb_read(REG_TDATA1);
    apb_read(REG_TDATA2);

    // Execute match per mode
    for (int m = 0; m < 3; m++) begin
      mode = (m == 0) ? 4'd0 : 4'(m + 1);
      base = ($urandom() & 32'h0FFF_FFF0) + 32'h100;
      // mcontrol6 first so tdata2 is stored unmasked
      apb_write(REG_TDATA1, 32'h6000_0044 | (xlen_t'(mode) << 7));
      apb_write(REG_TDATA2, base);
      drive_core(60, base);
    end

    // Loads and stores per mode
    for (int m = 0; m < 3; m++) begin
      mode = (m == 0) ? 4'd0 : 4'(m + 1);
      for (int kind = 1; kind <= 2; kind++) begin
        base = ($urandom() & 32'h0FFF_FFF0) + 32'h100;
        apb_write(REG_TDATA2, base);
        apb_write(REG_TDATA1, 32'h6000_0040 | (xlen_t'(mode) << 7) | xlen_t'(kind));
        drive_core(60, base);
      end
    end

    // Exception trigger on codes 2 and 7
    apb_write(REG_TDATA1, 32'h0);
    apb_write(REG_TSELECT, 32'd1);
    apb_write(REG_TDATA2, 32'h0000_0084);
    apb_write(REG_TDATA1, 32'h5000_0200);
    drive_core(120, 32'h1000);

    // Trigger 1 stops the cycle after its disable while trigger 0 keeps firing
    apb_write(REG_TSELECT, 32'd0);
    apb_write(REG_TDATA2, 32'h0);
    apb_write(REG_TDATA1, 32'h6000_0144);  // GE 0 on every fetch
    @(posedge clk);
    if_fetch.priv    <= PRIV_M;
    if_fetch.ptr     <= 1'b0;
    lsu_req.valid    <= 1'b0;
    wb_exc.exception <= 1'b1;
    wb_exc.cause     <= 11'd2;
    wb_exc.priv      <= PRIV_M;
    debug_mode       <= 1'b0;
    apb_write(REG_TSELECT, 32'd1);
    apb_write(REG_TDATA1, 32'hF000_0000);
    repeat (4) @(posedge clk);

    if ((hits_if == 0) || (hits_ex == 0) || (hits_wb == 0)) begin
      err_other++;
      $display("Stimulus never produced a hit on one of the three match outputs");
    end
    $display("errors: match %0d, bus %0d, other %0d", err_match, err_bus, err_other);
    if ((err_match + err_bus + err_other) == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    err_match = 0;
    err_bus   = 0;
    err_other = 0;
    hits_if   = 0;
    hits_ex   = 0;
    hits_wb   = 0;
    cycle_cnt = 0;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout, the stimulus did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: match %0d, bus %0d, other %0d", err_match, err_bus, err_other + 1);
      $display("Something failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: hw/dbg_trig_unit.sv
// Debug trigger unit top joining the APB register file and the trigger match bank
`default_nettype none

module dbg_trig_unit #(
  parameter int unsigned NUM_TRIGGERS = 2  // At least one trigger
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // APB slave
  input  dbg_trig_pkg::apb_req_t  apb_req_i,
  output dbg_trig_pkg::apb_rsp_t  apb_rsp_o,
  // Core pipeline
  input  dbg_trig_pkg::if_fetch_t if_fetch_i,
  input  dbg_trig_pkg::lsu_req_t  lsu_req_i,
  input  dbg_trig_pkg::wb_exc_t   wb_exc_i,
  input  logic                    debug_mode_i,
  // Trigger hits
  output logic                    match_if_o,
  output logic                    match_ex_o,
  output logic                    etrigger_wb_o
);

  import dbg_trig_pkg::*;

  // Per-trigger register state
  xlen_t tdata1 [NUM_TRIGGERS];
  xlen_t tdata2 [NUM_TRIGGERS];

  dbg_trig_regs #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) u_regs (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .tdata1_o  (tdata1),
    .tdata2_o  (tdata2)
  );

  // Purely combinational, new register values count from the next cycle
  dbg_trig_match_bank #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) u_match_bank (
    .tdata1_i      (tdata1),
    .tdata2_i      (tdata2),
    .if_fetch_i    (if_fetch_i),
    .lsu_req_i     (lsu_req_i),
    .wb_exc_i      (wb_exc_i),
    .debug_mode_i  (debug_mode_i),
    .match_if_o    (match_if_o),
    .match_ex_o    (match_ex_o),
    .etrigger_wb_o (etrigger_wb_o)
  );

endmodule

`default_nettype wire

// File: hw/dbg_trig_regs.sv
// Trigger register file behind an APB slave, with tselect/tdata1/tdata2 WARL handling
`default_nettype none

module dbg_trig_regs #(
  parameter int unsigned NUM_TRIGGERS = 2
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  dbg_trig_pkg::apb_req_t apb_req_i,
  output dbg_trig_pkg::apb_rsp_t apb_rsp_o,
  output dbg_trig_pkg::xlen_t    tdata1_o [NUM_TRIGGERS],
  output dbg_trig_pkg::xlen_t    tdata2_o [NUM_TRIGGERS]
);

  import dbg_trig_pkg::*;

  // Legal mcontrol6 value from raw write data
  function automatic xlen_t mc6_resolve(xlen_t wdata);
    xlen_t      val;
    logic [3:0] match_f;
    val     = '0;
    match_f = wdata[MC6_MATCH_HI:MC6_MATCH_LO];
    val[TDATA1_TYPE_HI:TDATA1_TYPE_LO] = TTYPE_MCONTROL6;
    val[TDATA1_DMODE]                  = 1'b1;
    val[MC6_ACTION_HI:MC6_ACTION_LO]   = MC6_ACTION_DEBUG;
    // Only GE and LT survive, anything else falls back to EQ
    if ((match_f == MATCH_GE) || (match_f == MATCH_LT)) begin
      val[MC6_MATCH_HI:MC6_MATCH_LO] = match_f;
    end
    val[MC6_M]       = wdata[MC6_M];
    val[MC6_EXECUTE] = wdata[MC6_EXECUTE];
    val[MC6_STORE]   = wdata[MC6_STORE];
    val[MC6_LOAD]    = wdata[MC6_LOAD];
    return val;  // U, S, chain, size, timing stay zero
  endfunction

  // Legal etrigger value from raw write data
  function automatic xlen_t etrig_resolve(xlen_t wdata);
    xlen_t val;
    val = '0;
    val[TDATA1_TYPE_HI:TDATA1_TYPE_LO]   = TTYPE_ETRIGGER;
    val[TDATA1_DMODE]                    = 1'b1;
    val[ETRIG_M]                         = wdata[ETRIG_M];
    val[ETRIG_ACTION_HI:ETRIG_ACTION_LO] = ETRIG_ACTION_DEBUG;
    return val;
  endfunction

  logic       apb_access;  // Access phase of a transfer
  logic       apb_write;
  logic       addr_valid;  // Offset hits one of the four registers
  logic       tselect_we;
  logic       tdata1_we;
  logic       tdata2_we;
  logic [3:0] wr_type;     // Type field of the write data
  logic [3:0] sel_type;    // Type of the selected trigger
  xlen_t      tselect_q;
  xlen_t      tselect_n;
  xlen_t      tdata1_q [NUM_TRIGGERS];
  xlen_t      tdata2_q [NUM_TRIGGERS];
  xlen_t      sel_tdata1;
  xlen_t      sel_tdata2;
  xlen_t      tdata1_n;
  xlen_t      tdata2_n;
  xlen_t      rdata;

  ////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////

  assign apb_access = apb_req_i.psel && apb_req_i.penable;
  assign apb_write  = apb_access && apb_req_i.pwrite;

  // Writes only land on a legal offset, TINFO is silently read-only
  assign tselect_we = apb_write && (apb_req_i.paddr == REG_TSELECT);
  assign tdata1_we  = apb_write && (apb_req_i.paddr == REG_TDATA1);
  assign tdata2_we  = apb_write && (apb_req_i.paddr == REG_TDATA2);

  // Selected trigger view
  always_comb begin
    sel_tdata1 = tdata1_q[0];
    sel_tdata2 = tdata2_q[0];
    for (int unsigned i = 0; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == xlen_t'(i)) begin
        sel_tdata1 = tdata1_q[i];
        sel_tdata2 = tdata2_q[i];
      end
    end
  end

  ////////////////////////////////////////
  // WARL resolution
  ////////////////////////////////////////

  // tselect only takes implemented indices
  assign tselect_n = (apb_req_i.pwdata < NUM_TRIGGERS) ? apb_req_i.pwdata : tselect_q;

  assign wr_type  = apb_req_i.pwdata[TDATA1_TYPE_HI:TDATA1_TYPE_LO];
  assign sel_type = sel_tdata1[TDATA1_TYPE_HI:TDATA1_TYPE_LO];

  always_comb begin
    tdata1_n = sel_tdata1;  // Unknown types keep the old value
    if ((apb_req_i.pwdata == '0) || (wr_type == TTYPE_DISABLED)) begin
      tdata1_n = TDATA1_DISABLED_VAL;
    end else if (wr_type == TTYPE_MCONTROL6) begin
      tdata1_n = mc6_resolve(apb_req_i.pwdata);
    end else if (wr_type == TTYPE_ETRIGGER) begin
      // Refused while tdata2 holds unimplemented exception codes
      if (!(|(sel_tdata2 & ~ETRIG_TDATA2_MASK))) begin
        tdata1_n = etrig_resolve(apb_req_i.pwdata);
      end
    end
  end

  // Exception triggers only hold implemented codes
  assign tdata2_n = (sel_type == TTYPE_ETRIGGER) ? (apb_req_i.pwdata & ETRIG_TDATA2_MASK) :
                                                   apb_req_i.pwdata;

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tselect_q <= '0;
    end else if (tselect_we) begin
      tselect_q <= tselect_n;
    end
  end

  for (genvar i = 0; i < NUM_TRIGGERS; i++) begin : gen_trig_regs
    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        tdata1_q[i] <= TDATA1_DISABLED_VAL;
        tdata2_q[i] <= '0;
      end else if (tselect_q == xlen_t'(i)) begin  // Only the selected trigger updates
        if (tdata1_we) begin
          tdata1_q[i] <= tdata1_n;
        end
        if (tdata2_we) begin
          tdata2_q[i] <= tdata2_n;
        end
      end
    end

    assign tdata1_o[i] = tdata1_q[i];
    assign tdata2_o[i] = tdata2_q[i];
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  always_comb begin
    addr_valid = 1'b1;
    case (apb_req_i.paddr)
      REG_TSELECT: rdata = tselect_q;
      REG_TDATA1:  rdata = sel_tdata1;
      REG_TDATA2:  rdata = sel_tdata2;
      REG_TINFO:   rdata = TINFO_VAL;
      default: begin
        rdata      = '0;
        addr_valid = 1'b0;  // Hole in the map
      end
    endcase
  end

  assign apb_rsp_o.prdata  = apb_access ? rdata : '0;  // Only driven in access phase
  assign apb_rsp_o.pready  = 1'b1;                     // Zero wait states
  assign apb_rsp_o.pslverr = apb_access && !addr_valid;

endmodule

`default_nettype wire

// File: hw/dbg_trig_match_bank.sv
// Match bank deriving the load/store byte span and combining all trigger comparators
`default_nettype none

module dbg_trig_match_bank #(
  parameter int unsigned NUM_TRIGGERS = 2
) (
  input  dbg_trig_pkg::xlen_t     tdata1_i [NUM_TRIGGERS],
  input  dbg_trig_pkg::xlen_t     tdata2_i [NUM_TRIGGERS],
  input  dbg_trig_pkg::if_fetch_t if_fetch_i,
  input  dbg_trig_pkg::lsu_req_t  lsu_req_i,
  input  dbg_trig_pkg::wb_exc_t   wb_exc_i,
  input  logic                    debug_mode_i,
  output logic                    match_if_o,     // Fetch address hit
  output logic                    match_ex_o,     // Load/store address hit
  output logic                    etrigger_wb_o   // Exception cause hit
);

  import dbg_trig_pkg::*;

  logic [1:0]              low_lsb;   // Lowest enabled byte index
  logic [1:0]              high_lsb;  // Highest enabled byte index
  xlen_t                   addr_low;
  xlen_t                   addr_high;
  logic [NUM_TRIGGERS-1:0] hit_if;
  logic [NUM_TRIGGERS-1:0] hit_ex;
  logic [NUM_TRIGGERS-1:0] hit_wb;

  // Byte span from the enables, shared by all comparators
  always_comb begin
    low_lsb  = 2'd0;
    high_lsb = 2'd0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_req_i.be[b]) high_lsb = 2'(b);  // Last set bit wins
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_req_i.be[b]) low_lsb = 2'(b);   // First set bit wins
    end
  end

  assign addr_low  = {lsu_req_i.addr[31:2], low_lsb};
  assign addr_high = {lsu_req_i.addr[31:2], high_lsb};

  // One comparator per trigger
  for (genvar i = 0; i < NUM_TRIGGERS; i++) begin : gen_cmp
    dbg_trig_comparator u_cmp (
      .tdata1_i        (tdata1_i[i]),
      .tdata2_i        (tdata2_i[i]),
      .if_fetch_i      (if_fetch_i),
      .lsu_req_i       (lsu_req_i),
      .lsu_addr_low_i  (addr_low),
      .lsu_addr_high_i (addr_high),
      .wb_exc_i        (wb_exc_i),
      .debug_mode_i    (debug_mode_i),
      .hit_if_o        (hit_if[i]),
      .hit_ex_o        (hit_ex[i]),
      .hit_wb_o        (hit_wb[i])
    );
  end

  assign match_if_o    = |hit_if;
  assign match_ex_o    = |hit_ex;
  assign etrigger_wb_o = |hit_wb;

endmodule

`default_nettype wire

// File: hw/dbg_trig_comparator.sv
// Single trigger comparator producing IF, EX and WB hits from one tdata1/tdata2 pair
`default_nettype none

module dbg_trig_comparator (
  input  dbg_trig_pkg::xlen_t     tdata1_i,
  input  dbg_trig_pkg::xlen_t     tdata2_i,
  input  dbg_trig_pkg::if_fetch_t if_fetch_i,
  input  dbg_trig_pkg::lsu_req_t  lsu_req_i,
  input  dbg_trig_pkg::xlen_t     lsu_addr_low_i,   // Lowest accessed byte
  input  dbg_trig_pkg::xlen_t     lsu_addr_high_i,  // Highest accessed byte
  input  dbg_trig_pkg::wb_exc_t   wb_exc_i,
  input  logic                    debug_mode_i,
  output logic                    hit_if_o,
  output logic                    hit_ex_o,
  output logic                    hit_wb_o
);

  import dbg_trig_pkg::*;

  logic [3:0]  trig_type;
  match_mode_e match_mode;
  logic        is_mc6;
  logic        is_etrig;
  logic        priv_if_en;   // M bit set and fetch in M mode
  logic        priv_ex_en;
  logic        priv_wb_en;
  logic        if_addr_hit;
  logic        ex_addr_hit;
  logic        ex_kind_en;   // Load or store selected for this access
  logic [3:0]  byte_hit;     // Enabled bytes matching tdata2[1:0]
  logic        cause_hit;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign trig_type  = tdata1_i[TDATA1_TYPE_HI:TDATA1_TYPE_LO];
  assign match_mode = match_mode_e'(tdata1_i[MC6_MATCH_HI:MC6_MATCH_LO]);
  assign is_mc6     = (trig_type == TTYPE_MCONTROL6);
  assign is_etrig   = (trig_type == TTYPE_ETRIGGER);

  // U bits are hardwired to zero, so only M mode can match
  assign priv_if_en = tdata1_i[MC6_M]   && (if_fetch_i.priv == PRIV_M);
  assign priv_ex_en = tdata1_i[MC6_M]   && (lsu_req_i.priv == PRIV_M);
  assign priv_wb_en = tdata1_i[ETRIG_M] && (wb_exc_i.priv == PRIV_M);

  ////////////////////////////////////////
  // Instruction fetch match
  ////////////////////////////////////////

  always_comb begin
    case (match_mode)
      MATCH_EQ: if_addr_hit = (if_fetch_i.pc == tdata2_i);
      MATCH_GE: if_addr_hit = (if_fetch_i.pc >= tdata2_i);
      default:  if_addr_hit = (if_fetch_i.pc <  tdata2_i);  // MATCH_LT
    endcase
  end

  assign hit_if_o = is_mc6 && tdata1_i[MC6_EXECUTE] && priv_if_en &&
                    !debug_mode_i && !if_fetch_i.ptr && if_addr_hit;

  ////////////////////////////////////////
  // Load/store match
  ////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_hit[b] = lsu_req_i.be[b] && (tdata2_i[1:0] == 2'(b));
    end
  end

  // GE looks at the top byte, LT at the bottom byte of the access
  always_comb begin
    case (match_mode)
      MATCH_EQ: ex_addr_hit = (lsu_req_i.addr[31:2] == tdata2_i[31:2]) && (|byte_hit);
      MATCH_GE: ex_addr_hit = (lsu_addr_high_i >= tdata2_i);
      default:  ex_addr_hit = (lsu_addr_low_i  <  tdata2_i);
    endcase
  end

  assign ex_kind_en = lsu_req_i.valid &&
                      ((tdata1_i[MC6_LOAD]  && !lsu_req_i.we) ||
                       (tdata1_i[MC6_STORE] &&  lsu_req_i.we));

  assign hit_ex_o = is_mc6 && ex_kind_en && priv_ex_en && !debug_mode_i && ex_addr_hit;

  ////////////////////////////////////////
  // Exception trigger
  ////////////////////////////////////////

  // tdata2 is a bitmap over the low 32 cause codes
  assign cause_hit = (wb_exc_i.cause < cause_t'(32)) && tdata2_i[wb_exc_i.cause[4:0]];

  assign hit_wb_o = is_etrig && wb_exc_i.exception && cause_hit &&
                    priv_wb_en && !debug_mode_i;

endmodule

`default_nettype wire

// File: hw/dbg_trig_pkg.sv
// Debug trigger package with register layout, trigger encodings and core-side structs
`default_nettype none

package dbg_trig_pkg;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  typedef logic [31:0] xlen_t;      // Data, address or CSR value
  typedef logic [10:0] cause_t;     // Exception cause in WB
  typedef logic [3:0]  apb_addr_t;  // APB register offset

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_lvl_e;

  typedef enum logic [3:0] {
    TTYPE_ETRIGGER  = 4'd5,   // Exception trigger
    TTYPE_MCONTROL6 = 4'd6,   // Address/data trigger
    TTYPE_DISABLED  = 4'd15
  } ttype_e;

  typedef enum logic [3:0] {
    MATCH_EQ = 4'd0,
    MATCH_GE = 4'd2,
    MATCH_LT = 4'd3
  } match_mode_e;

  // Register map
  localparam apb_addr_t REG_TSELECT = 4'h0;
  localparam apb_addr_t REG_TDATA1  = 4'h4;
  localparam apb_addr_t REG_TDATA2  = 4'h8;
  localparam apb_addr_t REG_TINFO   = 4'hC;

  ////////////////////////////////////////
  // tdata1 layout
  ////////////////////////////////////////

  localparam int unsigned TDATA1_TYPE_HI = 31;
  localparam int unsigned TDATA1_TYPE_LO = 28;
  localparam int unsigned TDATA1_DMODE   = 27;  // Debug-mode-only access

  localparam int unsigned MC6_ACTION_HI = 15;
  localparam int unsigned MC6_ACTION_LO = 12;
  localparam int unsigned MC6_MATCH_HI  = 10;
  localparam int unsigned MC6_MATCH_LO  = 7;
  localparam int unsigned MC6_M         = 6;
  localparam int unsigned MC6_EXECUTE   = 2;
  localparam int unsigned MC6_STORE     = 1;
  localparam int unsigned MC6_LOAD      = 0;

  localparam int unsigned ETRIG_M         = 9;
  localparam int unsigned ETRIG_ACTION_HI = 5;
  localparam int unsigned ETRIG_ACTION_LO = 0;

  localparam logic [3:0] MC6_ACTION_DEBUG   = 4'h1;  // Enter debug mode on hit
  localparam logic [5:0] ETRIG_ACTION_DEBUG = 6'h01;

  localparam xlen_t TDATA1_DISABLED_VAL = 32'hF800_0000;  // Type 15 with dmode
  localparam xlen_t ETRIG_TDATA2_MASK   = 32'h0000_08AF;  // Codes 0,1,2,3,5,7,11
  localparam xlen_t TINFO_VAL           = 32'h0000_8060;  // Types 5, 6 and 15

  ////////////////////////////////////////
  // Bus and pipeline structs
  ////////////////////////////////////////

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    xlen_t     pwdata;
  } apb_req_t;

  typedef struct packed {
    xlen_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  typedef struct packed {
    xlen_t     pc;
    logic      ptr;    // Table pointer fetch, never matched
    priv_lvl_e priv;
  } if_fetch_t;

  typedef struct packed {
    logic       valid;
    xlen_t      addr;
    logic       we;
    logic [3:0] be;
    priv_lvl_e  priv;
  } lsu_req_t;

  typedef struct packed {
    logic      exception;
    cause_t    cause;
    priv_lvl_e priv;
  } wb_exc_t;

endpackage

`default_nettype wire
